/* vlog.f */
noc_pkg.sv
flit_pkg.sv
route_compute.sv
input_port.sv
output_port.sv
router_top.sv
router_asserts.sv
tb_router.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_router -f vlog.f
	./obj_dir/Vtb_router | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb_router.sv */
`timescale 1ns/10ps

module tb_router;

   import noc_pkg::*;
   import flit_pkg::*;

   // router position under test
   localparam int tb_x = 1;
   localparam int tb_y = 0;

   // 16 directed, 2 contention, 45 random
   localparam int num_rand    = 45;
   localparam int num_pkts    = 16 + 2 + num_rand;
   localparam int cycle_limit = 400 + 20 * num_pkts;
   localparam int max_tags    = 64;

   logic                             clk;
   logic                             rst_n;
   logic [num_ports-1:0][flit_w-1:0] in_flit;
   logic [num_ports-1:0]             in_wr;
   logic [num_ports-1:0]             in_full;
   logic [num_ports-1:0][flit_w-1:0] out_flit;
   logic [num_ports-1:0]             out_valid;

   integer seed = 32'h6bc4_cb38;

   // expected packets, indexed by tag
   logic [flit_w-1:0] exp_flit [max_tags][4];
   int                exp_len  [max_tags];
   // tags still owed per output
   int                pend_q   [num_ports][$];
   int                next_tag    = 0;
   int                outstanding = 0;
   int                err_cnt     = 0;
   int                cycles      = 0;
   bit                any_written = 1'b0;

   // monitor state per output
   bit in_pkt  [num_ports];
   int cur_tag [num_ports];
   int cur_idx [num_ports];

   // random packet list drawn before the parallel phase
   int r_src [num_rand];
   int r_dx  [num_rand];
   int r_dy  [num_rand];
   int r_len [num_rand];
   int r_gap [num_rand];

   router_top #(
      .cur_x (tb_x),
      .cur_y (tb_y)
   ) DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_flit_0   (in_flit[0]),
      .in_flit_1   (in_flit[1]),
      .in_flit_2   (in_flit[2]),
      .in_flit_3   (in_flit[3]),
      .in_flit_4   (in_flit[4]),
      .in_wr_0     (in_wr[0]),
      .in_wr_1     (in_wr[1]),
      .in_wr_2     (in_wr[2]),
      .in_wr_3     (in_wr[3]),
      .in_wr_4     (in_wr[4]),
      .in_full_0   (in_full[0]),
      .in_full_1   (in_full[1]),
      .in_full_2   (in_full[2]),
      .in_full_3   (in_full[3]),
      .in_full_4   (in_full[4]),
      .out_flit_0  (out_flit[0]),
      .out_flit_1  (out_flit[1]),
      .out_flit_2  (out_flit[2]),
      .out_flit_3  (out_flit[3]),
      .out_flit_4  (out_flit[4]),
      .out_valid_0 (out_valid[0]),
      .out_valid_1 (out_valid[1]),
      .out_valid_2 (out_valid[2]),
      .out_valid_3 (out_valid[3]),
      .out_valid_4 (out_valid[4])
   );

   bind router_top router_asserts u_asserts (
      .clk       (clk),
      .rst_n     (rst_n),
      .out_valid (out_valid_a),
      .in_full   (in_full_a),
      .in_wr     (in_wr_a),
      .pop       (pop_a),
      .req_col   (req_col),
      .grant     (grant_a)
   );

   // 10 ns clock
   initial clk = 1'b0;
   always #5 clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   // XY rule, y grows southward
   function automatic int xy_route(input int dx, input int dy);
      if (dx > tb_x) return port_east;
      if (dx < tb_x) return port_west;
      if (dy > tb_y) return port_south;
      if (dy < tb_y) return port_north;
      return port_local;
   endfunction

   task automatic fail_now();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [flit_w-1:0] got,
                                input logic [flit_w-1:0] exp);
      if (got !== exp) begin
         err_cnt++;
         $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
         fail_now();
      end
   endtask

   // drive point is 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // one flit held off while the FIFO is full
   task automatic send_flit(input int p, input logic [flit_w-1:0] f);
      while (in_full[p]) begin
         next_cycle();
      end
      in_flit[p]  = f;
      in_wr[p]    = 1'b1;
      any_written = 1'b1;
      next_cycle();
      in_wr[p] = 1'b0;
   endtask

   task automatic send_packet(input int src, input int dx, input int dy, input int len);
      int                tag;
      int                port;
      logic [1:0]        ty;
      logic [flit_w-1:0] f;
      tag = next_tag;
      next_tag++;
      port = xy_route(dx, dy);
      exp_len[tag] = len;
      for (int i = 0; i < len; i++) begin
         if (i == 0) begin
            ty = (len == 1) ? flit_single : flit_head;
            f  = {ty, 6'(tag), 2'(dy), 2'(dx)};
         end else begin
            ty = (i == len - 1) ? flit_tail : flit_body;
            // payload from tag and index
            f  = {ty, 6'(tag), 4'(i * 3 + 1)};
         end
         exp_flit[tag][i] = f;
      end
      // expectation goes in before the first write
      pend_q[port].push_back(tag);
      outstanding++;
      for (int i = 0; i < len; i++) begin
         send_flit(src, exp_flit[tag][i]);
      end
   endtask

   // random packets belonging to one source
   task automatic send_stream(input int src);
      for (int k = 0; k < num_rand; k++) begin
         if (r_src[k] == src) begin
            repeat (r_gap[k]) next_cycle();
            send_packet(src, r_dx[k], r_dy[k], r_len[k]);
         end
      end
   endtask

   ////////////////////////////////////////
   // output monitor
   ////////////////////////////////////////

   always @(negedge clk) begin : monitor
      logic [flit_w-1:0] f;
      int                tag;
      int                pos;
      bit                opens;
      if (rst_n) begin
         for (int o = 0; o < num_ports; o++) begin
            if (out_valid[o]) begin
               f     = out_flit[o];
               tag   = int'(f[tag_hi:tag_lo]);
               opens = (f[type_hi:type_lo] == flit_head) ||
                       (f[type_hi:type_lo] == flit_single);
               pos   = -1;
               for (int i = 0; i < pend_q[o].size(); i++) begin
                  if (pend_q[o][i] == tag) pos = i;
               end
               if (!any_written) begin
                  $display("output %0d showed a flit before any flit was written", o);
                  fail_now();
               end else if (!in_pkt[o] && (!opens || pos < 0)) begin
                  $display("unexpected flit %h on output %0d, no pending packet matches", f, o);
                  fail_now();
               end else begin
                  // head claims its pending packet
                  if (!in_pkt[o]) begin
                     pend_q[o].delete(pos);
                     cur_tag[o] = tag;
                     cur_idx[o] = 0;
                     in_pkt[o]  = 1'b1;
                  end
                  // foreign flit inside a packet fails here
                  compare_value($sformatf("out_flit_%0d", o), f,
                                exp_flit[cur_tag[o]][cur_idx[o]]);
                  cur_idx[o]++;
                  if (cur_idx[o] == exp_len[cur_tag[o]]) begin
                     in_pkt[o] = 1'b0;
                     outstanding--;
                  end
               end
            end
         end
      end
   end

   // run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout after %0d cycles with %0d packets outstanding", cycles, outstanding);
         fail_now();
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin : stimulus
      logic [31:0] r;
      in_flit = '0;
      in_wr   = '0;
      rst_n   = 1'b0;
      for (int o = 0; o < num_ports; o++) begin
         in_pkt[o]  = 1'b0;
         cur_tag[o] = 0;
         cur_idx[o] = 0;
      end
      for (int k = 0; k < num_rand; k++) begin
         r        = $random(seed);
         r_src[k] = int'(r[15:8] % 8'd5);
         r_dx[k]  = int'(r[1:0]);
         r_dy[k]  = int'(r[3:2]);
         r_len[k] = int'(r[5:4]) + 1;
         r_gap[k] = int'(r[7:6]);
      end
      repeat (16) next_cycle();
      rst_n = 1'b1;
      // quiet outputs with nothing written
      repeat (5) next_cycle();

      // every mesh destination with rotating sources
      for (int d = 0; d < 16; d++) begin
         send_packet(d % num_ports, d % x_node_num, d / x_node_num, 1 + d % 4);
      end

      // two inputs race for the east output
      fork
         send_packet(1, 3, 0, 4);
         send_packet(2, 2, 1, 4);
      join

      // all sources at once so the FIFOs fill up
      fork
         send_stream(0);
         send_stream(1);
         send_stream(2);
         send_stream(3);
         send_stream(4);
      join

      wait (outstanding == 0);
      // stray flits would show up here
      repeat (10) next_cycle();
      if (err_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* router_asserts.sv */
`timescale 1ns/10ps

module router_asserts (
   input logic                                                  clk,
   input logic                                                  rst_n,
   input logic [noc_pkg::num_ports-1:0]                         out_valid,
   input logic [noc_pkg::num_ports-1:0]                         in_full,
   input logic [noc_pkg::num_ports-1:0]                         in_wr,
   input logic [noc_pkg::num_ports-1:0]                         pop,
   input logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] req_col,
   input logic [noc_pkg::num_ports-1:0][noc_pkg::num_ports-1:0] grant
);

   import noc_pkg::*;
   import flit_pkg::*;

   // flits held per input, from accepted writes and pops
   int occ [num_ports];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_ports; i++) begin
            occ[i] <= 0;
         end
      end else begin
         for (int i = 0; i < num_ports; i++) begin
            occ[i] <= occ[i] + int'(in_wr[i] && !in_full[i]) - int'(pop[i]);
         end
      end
   end

   ////////////////////////////////////////
   // reset and input side
   ////////////////////////////////////////

   // a reset edge leaves all outputs idle
   a_reset_quiet: assert property (@(posedge clk) !rst_n |=> (out_valid == '0))
      else $error("out_valid high after a reset edge");

   // full level tracks the buffered flit count
   for (genvar i = 0; i < num_ports; i++) begin : g_full
      a_full_level: assert property (@(posedge clk) disable iff (!rst_n)
                                     in_full[i] == (occ[i] == fifo_depth))
         else $error("in_full on input %0d disagrees with the FIFO occupancy", i);
   end

   ////////////////////////////////////////
   // arbiter grants
   ////////////////////////////////////////

   // at most one grant, and only to a requester
   for (genvar o = 0; o < num_ports; o++) begin : g_grant
      a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                                       $onehot0(grant[o]) &&
                                       ((grant[o] & ~req_col[o]) == '0))
         else $error("bad grant on output %0d", o);
   end

endmodule

/* router_top.sv */
`timescale 1ns/10ps

module router_top #(
   parameter int cur_x = 1,
   parameter int cur_y = 0
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic [flit_pkg::flit_w-1:0] in_flit_0,
   input  logic [flit_pkg::flit_w-1:0] in_flit_1,
   input  logic [flit_pkg::flit_w-1:0] in_flit_2,
   input  logic [flit_pkg::flit_w-1:0] in_flit_3,
   input  logic [flit_pkg::flit_w-1:0] in_flit_4,
   input  logic                        in_wr_0,
   input  logic                        in_wr_1,
   input  logic                        in_wr_2,
   input  logic                        in_wr_3,
   input  logic                        in_wr_4,
   output logic                        in_full_0,
   output logic                        in_full_1,
   output logic                        in_full_2,
   output logic                        in_full_3,
   output logic                        in_full_4,
   output logic [flit_pkg::flit_w-1:0] out_flit_0,
   output logic [flit_pkg::flit_w-1:0] out_flit_1,
   output logic [flit_pkg::flit_w-1:0] out_flit_2,
   output logic [flit_pkg::flit_w-1:0] out_flit_3,
   output logic [flit_pkg::flit_w-1:0] out_flit_4,
   output logic                        out_valid_0,
   output logic                        out_valid_1,
   output logic                        out_valid_2,
   output logic                        out_valid_3,
   output logic                        out_valid_4
);

   import noc_pkg::*;
   import flit_pkg::*;

   logic [num_ports-1:0][flit_w-1:0]     in_flit_a;
   logic [num_ports-1:0][flit_w-1:0]     front_a;
   logic [num_ports-1:0][flit_w-1:0]     out_flit_a;
   logic [num_ports-1:0]                 in_wr_a;
   logic [num_ports-1:0]                 in_full_a;
   logic [num_ports-1:0]                 out_valid_a;
   logic [num_ports-1:0]                 pop_a;
   // rows by input, columns by output
   logic [num_ports-1:0][port_sel_w-1:0] req_row;
   logic [num_ports-1:0][num_ports-1:0]  req_col;
   // indexed by output, then input
   logic [num_ports-1:0][num_ports-1:0]  grant_a;

   // port 0 sits in the low slice
   assign in_flit_a = {in_flit_4, in_flit_3, in_flit_2, in_flit_1, in_flit_0};
   assign in_wr_a   = {in_wr_4, in_wr_3, in_wr_2, in_wr_1, in_wr_0};
   assign {in_full_4, in_full_3, in_full_2, in_full_1, in_full_0} = in_full_a;
   assign {out_flit_4, out_flit_3, out_flit_2, out_flit_1, out_flit_0} = out_flit_a;
   assign {out_valid_4, out_valid_3, out_valid_2, out_valid_1, out_valid_0} = out_valid_a;

   ////////////////////////////////////////
   // request transpose and pop merge
   ////////////////////////////////////////

   always_comb begin
      req_col = '0;
      pop_a   = '0;
      for (int o = 0; o < num_ports; o++) begin
         for (int i = 0; i < num_ports; i++) begin
            req_col[o][i] = req_row[i][o];
            // any output granting input i pops it
            pop_a[i] = pop_a[i] | grant_a[o][i];
         end
      end
   end

   for (genvar i = 0; i < num_ports; i++) begin : g_in
      input_port #(
         .cur_x (cur_x),
         .cur_y (cur_y)
      ) u_in (
         .clk        (clk),
         .rst_n      (rst_n),
         .in_flit    (in_flit_a[i]),
         .in_wr      (in_wr_a[i]),
         .in_full    (in_full_a[i]),
         .req        (req_row[i]),
         .front_flit (front_a[i]),
         .pop        (pop_a[i])
      );
   end

   // every output sees every front flit
   for (genvar o = 0; o < num_ports; o++) begin : g_out
      output_port u_out (
         .clk       (clk),
         .rst_n     (rst_n),
         .req_col   (req_col[o]),
         .flit_0    (front_a[0]),
         .flit_1    (front_a[1]),
         .flit_2    (front_a[2]),
         .flit_3    (front_a[3]),
         .flit_4    (front_a[4]),
         .grant     (grant_a[o]),
         .out_flit  (out_flit_a[o]),
         .out_valid (out_valid_a[o])
      );
   end

endmodule

/* output_port.sv */
`timescale 1ns/10ps

module output_port (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [noc_pkg::num_ports-1:0] req_col,
   input  logic [flit_pkg::flit_w-1:0]   flit_0,
   input  logic [flit_pkg::flit_w-1:0]   flit_1,
   input  logic [flit_pkg::flit_w-1:0]   flit_2,
   input  logic [flit_pkg::flit_w-1:0]   flit_3,
   input  logic [flit_pkg::flit_w-1:0]   flit_4,
   output logic [noc_pkg::num_ports-1:0] grant,
   output logic [flit_pkg::flit_w-1:0]   out_flit,
   output logic                          out_valid
);

   import noc_pkg::*;
   import flit_pkg::*;

   typedef logic [$bits(port_e)-1:0] idx_t;

   // idle arbitrates, busy stays with the owner
   typedef enum logic {
      arb_idle = 1'b0,
      arb_busy = 1'b1
   } arb_state_e;

   arb_state_e                     state;
   idx_t                           owner;
   idx_t                           rr_ptr;
   idx_t                           pick;
   idx_t                           src;
   idx_t                           rr_next;
   logic                           found;
   logic                           fwd;
   logic [flit_w-1:0]              sel_flit;
   logic [num_ports-1:0][flit_w-1:0] flit_a;

   assign flit_a = {flit_4, flit_3, flit_2, flit_1, flit_0};

   ////////////////////////////////////////
   // round-robin search
   ////////////////////////////////////////

   // first requester from rr_ptr upward
   always_comb begin
      int idx;
      pick  = rr_ptr;
      found = 1'b0;
      for (int k = 0; k < num_ports; k++) begin
         idx = (int'(rr_ptr) + k) % num_ports;
         if (!found && req_col[idx]) begin
            found = 1'b1;
            pick  = idx_t'(idx);
         end
      end
   end

   assign rr_next = (int'(pick) == num_ports - 1) ? '0 : pick + 1'b1;

   // locked owner wins over the search
   assign src      = (state == arb_busy) ? owner : pick;
   assign fwd      = (state == arb_busy) ? req_col[owner] : found;
   assign sel_flit = flit_a[src];

   always_comb begin
      grant = '0;
      if (fwd) begin
         grant[src] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // packet lock
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= arb_idle;
         owner     <= '0;
         rr_ptr    <= '0;
         out_valid <= 1'b0;
      end else begin
         out_valid <= fwd;
         case (state)
            arb_idle: begin
               if (found) begin
                  owner  <= pick;
                  rr_ptr <= rr_next;
                  // single flit frees the port at once
                  if (!is_tail(sel_flit)) begin
                     state <= arb_busy;
                  end
               end
            end
            arb_busy: begin
               if (fwd && is_tail(sel_flit)) begin
                  state <= arb_idle;
               end
            end
            default: state <= arb_idle;
         endcase
      end
   end

   // registered output flit
   always_ff @(posedge clk) begin
      if (fwd) begin
         out_flit <= sel_flit;
      end
   end

endmodule

/* input_port.sv */
`timescale 1ns/10ps

module input_port #(
   parameter int cur_x = 1,
   parameter int cur_y = 0
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [flit_pkg::flit_w-1:0]    in_flit,
   input  logic                           in_wr,
   output logic                           in_full,
   output logic [noc_pkg::port_sel_w-1:0] req,
   output logic [flit_pkg::flit_w-1:0]    front_flit,
   input  logic                           pop
);

   import noc_pkg::*;
   import flit_pkg::*;

   typedef logic [$clog2(fifo_depth)-1:0]   ptr_t;
   typedef logic [$clog2(fifo_depth+1)-1:0] cnt_t;

   logic [flit_w-1:0]     mem [fifo_depth];
   ptr_t                  wr_ptr;
   ptr_t                  rd_ptr;
   cnt_t                  cnt;
   logic                  empty;
   logic                  do_push;
   logic                  do_pop;
   logic [port_sel_w-1:0] route_en;
   logic [port_sel_w-1:0] held_route;

   ////////////////////////////////////////
   // circular flit buffer
   ////////////////////////////////////////

   assign empty   = (cnt == '0);
   assign in_full = (cnt == cnt_t'(fifo_depth));
   // sender keeps in_wr low while full
   assign do_push = in_wr && !in_full;
   assign do_pop  = pop && !empty;

   assign front_flit = mem[rd_ptr];

   // payload store
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // occupancy
         case ({do_push, do_pop})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;
         endcase
      end
   end

   ////////////////////////////////////////
   // route lookup and hold
   ////////////////////////////////////////

   route_compute #(
      .cur_x (cur_x),
      .cur_y (cur_y)
   ) u_route (
      .dest_x   (front_flit[dest_x_hi:dest_x_lo]),
      .dest_y   (front_flit[dest_y_hi:dest_y_lo]),
      .port_num (),
      .port_en  (route_en)
   );

   // tail pop ends the packet, head at front opens one
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         held_route <= '0;
      end else if (do_pop && is_tail(front_flit)) begin
         held_route <= '0;
      end else if (!empty && is_head(front_flit)) begin
         held_route <= route_en;
      end
   end

   // head requests straight away, body and tail use the held route
   always_comb begin
      if (empty) begin
         req = '0;
      end else if (is_head(front_flit)) begin
         req = route_en;
      end else begin
         req = held_route;
      end
   end

endmodule

/* route_compute.sv */
`timescale 1ns/10ps

module route_compute #(
   parameter int cur_x = 1,
   parameter int cur_y = 0
) (
   input  logic [noc_pkg::x_width-1:0]    dest_x,
   input  logic [noc_pkg::y_width-1:0]    dest_y,
   output noc_pkg::port_e                 port_num,
   output logic [noc_pkg::port_sel_w-1:0] port_en
);

   import noc_pkg::*;

   // own position, cut to coordinate width
   localparam logic [x_width-1:0] here_x = x_width'(cur_x);
   localparam logic [y_width-1:0] here_y = y_width'(cur_y);

   ////////////////////////////////////////
   // dimension-order XY decision
   ////////////////////////////////////////

   always_comb begin
      // x first
      if (dest_x > here_x) begin
         port_num = port_east;
      end else if (dest_x < here_x) begin
         port_num = port_west;
      // column reached, then y
      // y grows southward
      end else if (dest_y > here_y) begin
         port_num = port_south;
      end else if (dest_y < here_y) begin
         port_num = port_north;
      end else begin
         // arrived
         port_num = port_local;
      end
   end

   ////////////////////////////////////////
   // one-hot enable
   ////////////////////////////////////////

   // bit index equals port number
   always_comb begin
      port_en = '0;
      port_en[port_num] = 1'b1;
   end

endmodule

/* flit_pkg.sv */
package flit_pkg;

   localparam int flit_w     = 12;
   // entries per input buffer
   localparam int fifo_depth = 4;

   // single counts as head and tail at once
   typedef enum logic [1:0] {
      flit_body   = 2'd0,
      flit_tail   = 2'd1,
      flit_head   = 2'd2,
      flit_single = 2'd3
   } flit_type_e;

   ////////////////////////////////////////
   // head flit layout
   ////////////////////////////////////////

   localparam int type_hi   = 11;
   localparam int type_lo   = 10;
   localparam int tag_hi    = 9;
   localparam int tag_lo    = 4;
   localparam int dest_y_hi = 3;
   localparam int dest_y_lo = 2;
   localparam int dest_x_hi = 1;
   localparam int dest_x_lo = 0;

   function automatic flit_type_e get_type(input logic [flit_w-1:0] f);
      return flit_type_e'(f[type_hi:type_lo]);
   endfunction

   // opens a packet
   function automatic logic is_head(input logic [flit_w-1:0] f);
      return (get_type(f) == flit_head) || (get_type(f) == flit_single);
   endfunction

   // closes a packet
   function automatic logic is_tail(input logic [flit_w-1:0] f);
      return (get_type(f) == flit_tail) || (get_type(f) == flit_single);
   endfunction

endpackage

/* noc_pkg.sv */
package noc_pkg;

   ////////////////////////////////////////
   // mesh geometry
   ////////////////////////////////////////

   // 4 by 4 mesh
   localparam int x_node_num = 4;
   localparam int y_node_num = 4;

   // coordinate widths follow the mesh size
   localparam int x_width = $clog2(x_node_num);
   localparam int y_width = $clog2(y_node_num);

   ////////////////////////////////////////
   // router ports
   ////////////////////////////////////////

   // local plus four neighbours
   localparam int num_ports  = 5;
   // request and grant vectors, one bit per port
   localparam int port_sel_w = num_ports;

   // port number doubles as the one-hot enable index
   typedef enum logic [2:0] {
      port_local = 3'd0,
      port_east  = 3'd1,
      port_north = 3'd2,
      port_west  = 3'd3,
      port_south = 3'd4
   } port_e;

endpackage
